//--- flist.f
hw/trail_pkg.sv
hw/fb_bus_if.sv
hw/fb_port_if.sv
hw/trail_writer.sv
hw/fb_arbiter.sv
hw/trail_ram.sv
hw/trail_subsystem.sv
verif/tb_trail_subsystem.sv

//--- hw/fb_arbiter.sv
// round-robin arbiter for two writers on the single RAM port
// clear is only expected while both writers are idle
`timescale 1ns/1ps

module fb_arbiter #(
	parameter int COORD_BITS = trail_pkg::COORD_BITS_DEFAULT
) (
	input  logic       Clk,
	input  logic       arst_n,
	input  logic       ready,
	fb_bus_if.arbiter  blue,
	fb_bus_if.arbiter  red,
	fb_port_if.master  ram
);
	import trail_pkg::*;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ADDR,
		ARB_DATA,
		ARB_ACK
	} arb_state_t;

	arb_state_t state;
	player_t    grant;
	player_t    last_served;
	logic       ack_q;
	cell_code_t rdata_q;

	// request of the granted bus
	logic                    sel_req;
	logic                    sel_we;
	logic [2*COORD_BITS-1:0] sel_addr;
	cell_code_t              sel_wdata;

	always_comb
	begin
		if (grant == PLAYER_RED)
		begin
			sel_req   = red.req;
			sel_we    = red.we;
			sel_addr  = red.addr;
			sel_wdata = red.wdata;
		end
		else
		begin
			sel_req   = blue.req;
			sel_we    = blue.we;
			sel_addr  = blue.addr;
			sel_wdata = blue.wdata;
		end
	end

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state       <= ARB_IDLE;
			grant       <= PLAYER_BLUE;
			last_served <= PLAYER_RED;
			ack_q       <= 1'b0;
		end
		else
		begin
			case (state)
				ARB_IDLE:
					if (ready && (blue.req || red.req))
					begin
						// red wins a tie only when blue went last
						if (red.req && (!blue.req || (last_served == PLAYER_BLUE)))
							grant <= PLAYER_RED;
						else
							grant <= PLAYER_BLUE;
						state <= ARB_ADDR;
					end
				ARB_ADDR:
					state <= ARB_DATA;
				ARB_DATA:
				begin
					ack_q       <= 1'b1;
					last_served <= grant;
					state       <= ARB_ACK;
				end
				ARB_ACK:
					if (!sel_req)
					begin
						ack_q <= 1'b0;
						state <= ARB_IDLE;
					end
				default:
					state <= ARB_IDLE;
			endcase
		end
	end

	// read data lands in the data phase
	always_ff @(posedge Clk)
	begin
		if (state == ARB_DATA)
			rdata_q <= ram.rdata;
	end

	assign ram.we     = (state == ARB_ADDR) && sel_we;
	assign ram.addr   = sel_addr;
	assign ram.wdata  = sel_wdata;
	assign blue.ack   = ack_q && (grant == PLAYER_BLUE);
	assign red.ack    = ack_q && (grant == PLAYER_RED);
	assign blue.rdata = rdata_q;
	assign red.rdata  = rdata_q;

	// ack may outlive req by one cycle only
	a_blue_ack_has_req: assert property (
		@(posedge Clk) disable iff (!arst_n)
		blue.ack |-> $past(blue.req)
	);

	a_red_ack_has_req: assert property (
		@(posedge Clk) disable iff (!arst_n)
		red.ack |-> $past(red.req)
	);

endmodule

//--- hw/fb_bus_if.sv
// four-phase req/ack bus from one trail writer to the arbiter
// rdata is only meaningful while ack is high
`timescale 1ns/1ps

interface fb_bus_if #(
	parameter int COORD_BITS = trail_pkg::COORD_BITS_DEFAULT
);
	import trail_pkg::*;

	logic                    req;
	logic                    ack;
	logic                    we;
	logic [2*COORD_BITS-1:0] addr;
	cell_code_t              wdata;
	cell_code_t              rdata;

	// writer side
	modport requester (output req, output we, output addr, output wdata,
		input ack, input rdata);

	// arbiter side
	modport arbiter (input req, input we, input addr, input wdata,
		output ack, output rdata);

endinterface

//--- hw/fb_port_if.sv
// single access port from the arbiter to the trail RAM
// reads return data one cycle after the address
`timescale 1ns/1ps

interface fb_port_if #(
	parameter int COORD_BITS = trail_pkg::COORD_BITS_DEFAULT
);
	import trail_pkg::*;

	logic                    we;
	logic [2*COORD_BITS-1:0] addr;
	cell_code_t              wdata;
	cell_code_t              rdata;

	modport master (output we, output addr, output wdata, input rdata);

	modport slave (input we, input addr, input wdata, output rdata);

endinterface

//--- hw/trail_pkg.sv
// shared cell codes, directions and player ids for the trail memory
// cell codes are 3 bits wide, values 6 and 7 are never written
package trail_pkg;

	// default grid is 32 by 32 cells
	localparam int COORD_BITS_DEFAULT = 5;

	typedef enum logic [2:0] {
		CELL_EMPTY  = 3'd0,
		CELL_BLUE_H = 3'd1,
		CELL_BLUE_V = 3'd2,
		CELL_RED_H  = 3'd3,
		CELL_RED_V  = 3'd4,
		CELL_CORNER = 3'd5
	} cell_code_t;

	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_t;

	typedef enum logic {
		PLAYER_BLUE = 1'b0,
		PLAYER_RED  = 1'b1
	} player_t;

	// code left in the cell a head has just moved out of
	function automatic cell_code_t trail_code(input player_t player, input dir_t prev_dir,
		input dir_t new_dir);
		cell_code_t code;
		if (prev_dir != new_dir)
			code = CELL_CORNER;
		else if ((new_dir == DIR_UP) || (new_dir == DIR_DOWN))
			code = (player == PLAYER_BLUE) ? CELL_BLUE_V : CELL_RED_V;
		else
			code = (player == PLAYER_BLUE) ? CELL_BLUE_H : CELL_RED_H;
		return code;
	endfunction

endpackage

//--- hw/trail_ram.sv
// trail RAM with one read-write port and one video read port, both one cycle latency
// a full clear sweep takes one cycle per cell
`timescale 1ns/1ps

module trail_ram #(
	parameter int COORD_BITS = trail_pkg::COORD_BITS_DEFAULT
) (
	input  logic                    Clk,
	input  logic                    arst_n,
	input  logic                    clear,
	input  logic [2*COORD_BITS-1:0] vid_addr,
	output logic                    ready,
	output trail_pkg::cell_code_t   vid_code,
	fb_port_if.slave                port
);
	import trail_pkg::*;

	localparam int DEPTH = 1 << (2*COORD_BITS);

	cell_code_t mem [0:DEPTH-1];

	logic                    sweeping;
	logic [2*COORD_BITS-1:0] sweep_addr;

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sweeping   <= 1'b1;
			sweep_addr <= '0;
		end
		else if (clear)
		begin
			sweeping   <= 1'b1;
			sweep_addr <= '0;
		end
		else if (sweeping)
		begin
			sweep_addr <= sweep_addr + 1'b1;
			// last cell written this cycle
			if (&sweep_addr)
				sweeping <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (sweeping)
			mem[sweep_addr] <= CELL_EMPTY;
		else if (port.we)
			mem[port.addr] <= port.wdata;
		port.rdata <= mem[port.addr];
		vid_code   <= mem[vid_addr];
	end

	assign ready = !sweeping;

	a_no_write_in_sweep: assert property (
		@(posedge Clk) disable iff (!arst_n)
		!ready |-> !port.we
	);

endmodule

//--- hw/trail_subsystem.sv
// trail memory top, two writers share the RAM through a round-robin arbiter
// a move is finished in RAM once that player's busy falls
`timescale 1ns/1ps

module trail_subsystem #(
	parameter int COORD_BITS = trail_pkg::COORD_BITS_DEFAULT
) (
	input  logic                    Clk,
	input  logic                    arst_n,
	input  logic                    run,
	input  logic                    clear,
	input  logic [COORD_BITS-1:0]   blue_x,
	input  logic [COORD_BITS-1:0]   blue_y,
	input  trail_pkg::dir_t         blue_dir,
	input  logic [COORD_BITS-1:0]   red_x,
	input  logic [COORD_BITS-1:0]   red_y,
	input  trail_pkg::dir_t         red_dir,
	input  logic [2*COORD_BITS-1:0] vid_addr,
	output trail_pkg::cell_code_t   vid_code,
	output logic                    ready,
	output logic                    blue_busy,
	output logic                    red_busy,
	output logic                    blue_crash,
	output logic                    red_crash
);
	import trail_pkg::*;

	fb_bus_if  #(.COORD_BITS(COORD_BITS)) blue_bus ();
	fb_bus_if  #(.COORD_BITS(COORD_BITS)) red_bus ();
	fb_port_if #(.COORD_BITS(COORD_BITS)) ram_port ();

	trail_writer #(
		.PLAYER     (PLAYER_BLUE),
		.COORD_BITS (COORD_BITS)
	) u_blue_writer (
		.Clk    (Clk),
		.arst_n (arst_n),
		.run    (run),
		.x      (blue_x),
		.y      (blue_y),
		.dir    (blue_dir),
		.busy   (blue_busy),
		.crash  (blue_crash),
		.bus    (blue_bus.requester)
	);

	trail_writer #(
		.PLAYER     (PLAYER_RED),
		.COORD_BITS (COORD_BITS)
	) u_red_writer (
		.Clk    (Clk),
		.arst_n (arst_n),
		.run    (run),
		.x      (red_x),
		.y      (red_y),
		.dir    (red_dir),
		.busy   (red_busy),
		.crash  (red_crash),
		.bus    (red_bus.requester)
	);

	fb_arbiter #(
		.COORD_BITS (COORD_BITS)
	) u_arbiter (
		.Clk    (Clk),
		.arst_n (arst_n),
		.ready  (ready),
		.blue   (blue_bus.arbiter),
		.red    (red_bus.arbiter),
		.ram    (ram_port.master)
	);

	trail_ram #(
		.COORD_BITS (COORD_BITS)
	) u_ram (
		.Clk      (Clk),
		.arst_n   (arst_n),
		.clear    (clear),
		.vid_addr (vid_addr),
		.ready    (ready),
		.vid_code (vid_code),
		.port     (ram_port.slave)
	);

endmodule

//--- hw/trail_writer.sv
// one player's trail writer, a move costs a collision read then a trail write
// x and y must be held by the source until busy falls
`timescale 1ns/1ps

module trail_writer #(
	parameter trail_pkg::player_t PLAYER     = trail_pkg::PLAYER_BLUE,
	parameter int                 COORD_BITS = trail_pkg::COORD_BITS_DEFAULT
) (
	input  logic                  Clk,
	input  logic                  arst_n,
	input  logic                  run,
	input  logic [COORD_BITS-1:0] x,
	input  logic [COORD_BITS-1:0] y,
	input  trail_pkg::dir_t       dir,
	output logic                  busy,
	output logic                  crash,
	fb_bus_if.requester           bus
);
	import trail_pkg::*;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_RD_REQ,
		WR_RD_REL,
		WR_WR_REQ,
		WR_WR_REL
	} wr_state_t;

	wr_state_t state;

	// head and direction as of the last accepted move
	logic [COORD_BITS-1:0] prev_x;
	logic [COORD_BITS-1:0] prev_y;
	dir_t                  prev_dir;

	// cell left behind, cell entered and the mark for the old cell
	logic [2*COORD_BITS-1:0] old_addr;
	logic [2*COORD_BITS-1:0] new_addr;
	cell_code_t              code_q;

	logic moved;

	assign moved = run && ((x != prev_x) || (y != prev_y));

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= WR_IDLE;
			prev_x   <= '0;
			prev_y   <= '0;
			prev_dir <= DIR_UP;
			crash    <= 1'b0;
		end
		else
		begin
			// outside a round the start position is tracked directly
			if (!run)
			begin
				prev_x   <= x;
				prev_y   <= y;
				prev_dir <= dir;
				crash    <= 1'b0;
			end

			case (state)
				WR_IDLE:
					if (moved)
					begin
						prev_x   <= x;
						prev_y   <= y;
						prev_dir <= dir;
						state    <= WR_RD_REQ;
					end
				WR_RD_REQ:
					if (bus.ack)
					begin
						// any trail in the entered cell is a crash
						if (run && (bus.rdata != CELL_EMPTY))
							crash <= 1'b1;
						state <= WR_RD_REL;
					end
				WR_RD_REL:
					if (!bus.ack)
						state <= WR_WR_REQ;
				WR_WR_REQ:
					if (bus.ack)
						state <= WR_WR_REL;
				WR_WR_REL:
					if (!bus.ack)
						state <= WR_IDLE;
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	// captured move data, no reset needed
	always_ff @(posedge Clk)
	begin
		if ((state == WR_IDLE) && moved)
		begin
			old_addr <= {prev_y, prev_x};
			new_addr <= {y, x};
			code_q   <= trail_code(PLAYER, prev_dir, dir);
		end
	end

	assign busy      = (state != WR_IDLE);
	assign bus.req   = (state == WR_RD_REQ) || (state == WR_WR_REQ);
	assign bus.we    = (state == WR_WR_REQ);
	assign bus.addr  = (state == WR_WR_REQ) ? old_addr : new_addr;
	assign bus.wdata = code_q;

	// four-phase rule, the arbiter answers before req is withdrawn
	a_req_held_until_ack: assert property (
		@(posedge Clk) disable iff (!arst_n)
		$fell(bus.req) |-> bus.ack
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compiles and runs tb_trail_subsystem with Verilator, the result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_trail_subsystem -f flist.f \
	--Mdir obj_dir -o sim_tb > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -qx "=== PASS ===" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- verif/tb_trail_subsystem.sv
// self-checking testbench for the trail memory, with a grid model and a crash model per player
// random moves keep blue in the left half and red in the right half of the grid
`timescale 1ns/1ps

module tb_trail_subsystem;
	import trail_pkg::*;

	localparam int COORD_BITS    = 5;
	localparam int DEPTH         = 1 << (2*COORD_BITS);
	localparam int MOVE_TIMEOUT  = 200;
	localparam int READY_TIMEOUT = 2*DEPTH;
	localparam int RANDOM_MOVES  = 60;

	logic                    Clk;
	logic                    arst_n;
	logic                    run;
	logic                    clear;
	logic [COORD_BITS-1:0]   blue_x;
	logic [COORD_BITS-1:0]   blue_y;
	dir_t                    blue_dir;
	logic [COORD_BITS-1:0]   red_x;
	logic [COORD_BITS-1:0]   red_y;
	dir_t                    red_dir;
	logic [2*COORD_BITS-1:0] vid_addr;
	cell_code_t              vid_code;
	logic                    ready;
	logic                    blue_busy;
	logic                    red_busy;
	logic                    blue_crash;
	logic                    red_crash;

	// model state, index 0 is blue and 1 is red
	cell_code_t            grid [0:DEPTH-1];
	logic [COORD_BITS-1:0] pos_x [0:1];
	logic [COORD_BITS-1:0] pos_y [0:1];
	dir_t                  pos_dir [0:1];
	logic                  crash_m [0:1];
	int                    seed;

	trail_subsystem #(
		.COORD_BITS (COORD_BITS)
	) UUT (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.run        (run),
		.clear      (clear),
		.blue_x     (blue_x),
		.blue_y     (blue_y),
		.blue_dir   (blue_dir),
		.red_x      (red_x),
		.red_y      (red_y),
		.red_dir    (red_dir),
		.vid_addr   (vid_addr),
		.vid_code   (vid_code),
		.ready      (ready),
		.blue_busy  (blue_busy),
		.red_busy   (red_busy),
		.blue_crash (blue_crash),
		.red_crash  (red_crash)
	);

	initial
	begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// mark left in the cell a head leaves
	function automatic cell_code_t expected_code(input int p, input dir_t from_dir,
		input dir_t to_dir);
		if (from_dir != to_dir)
			return CELL_CORNER;
		case (to_dir)
			DIR_UP, DIR_DOWN: return (p == 1) ? CELL_RED_V : CELL_BLUE_V;
			default:          return (p == 1) ? CELL_RED_H : CELL_BLUE_H;
		endcase
	endfunction

	// up is toward smaller y, coordinates wrap at the grid edge
	function automatic logic [COORD_BITS-1:0] next_x(input logic [COORD_BITS-1:0] x,
		input dir_t d);
		case (d)
			DIR_LEFT:  return x - 1'b1;
			DIR_RIGHT: return x + 1'b1;
			default:   return x;
		endcase
	endfunction

	function automatic logic [COORD_BITS-1:0] next_y(input logic [COORD_BITS-1:0] y,
		input dir_t d);
		case (d)
			DIR_UP:   return y - 1'b1;
			DIR_DOWN: return y + 1'b1;
			default:  return y;
		endcase
	endfunction

	// true when the move would take a head out of its own half
	function automatic logic leaves_half(input int p, input dir_t d);
		logic [COORD_BITS-1:0] nx;
		nx = next_x(pos_x[p], d);
		return nx[COORD_BITS-1] != p[0];
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_code(input string name, input cell_code_t exp, input cell_code_t act);
		if (exp !== act)
			abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
			abort_run($sformatf("Mismatch %s: expected %0b, actual %0b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act)
			abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// counts the cycles spent with ready low
	task automatic wait_ready(input string name, output int cycles);
		int n;
		n = 0;
		while (!ready)
		begin
			if (n >= READY_TIMEOUT)
				abort_run($sformatf("%s: ready never rose", name));
			n++;
			@(negedge Clk);
		end
		cycles = n;
	endtask

	task automatic drive_heads();
		blue_x   = pos_x[0];
		blue_y   = pos_y[0];
		blue_dir = pos_dir[0];
		red_x    = pos_x[1];
		red_y    = pos_y[1];
		red_dir  = pos_dir[1];
	endtask

	task automatic check_cell(input string name, input logic [COORD_BITS-1:0] x,
		input logic [COORD_BITS-1:0] y);
		@(negedge Clk);
		vid_addr = {y, x};
		@(negedge Clk);
		check_code(name, grid[{y, x}], vid_code);
	endtask

	// video reads are pipelined, one address per cycle
	task automatic check_grid(input string name);
		int a;
		for (a = 0; a <= DEPTH; a++)
		begin
			@(negedge Clk);
			if (a > 0)
				check_code($sformatf("%s cell %0d", name, a - 1), grid[a - 1], vid_code);
			if (a < DEPTH)
				vid_addr = a[2*COORD_BITS-1:0];
		end
	endtask

	// read of the entered cell, then the mark on the cell left
	task automatic step_player(input int p, input dir_t d);
		logic [COORD_BITS-1:0] nx;
		logic [COORD_BITS-1:0] ny;
		nx = next_x(pos_x[p], d);
		ny = next_y(pos_y[p], d);
		if (grid[{ny, nx}] != CELL_EMPTY)
			crash_m[p] = 1'b1;
		grid[{pos_y[p], pos_x[p]}] = expected_code(p, pos_dir[p], d);
		pos_x[p]   = nx;
		pos_y[p]   = ny;
		pos_dir[p] = d;
	endtask

	// drops run, places both heads and starts a new round
	task automatic start_round(input logic [COORD_BITS-1:0] bx, input logic [COORD_BITS-1:0] by,
		input dir_t bd, input logic [COORD_BITS-1:0] rx, input logic [COORD_BITS-1:0] ry,
		input dir_t rd);
		@(negedge Clk);
		run        = 1'b0;
		pos_x[0]   = bx;
		pos_y[0]   = by;
		pos_dir[0] = bd;
		pos_x[1]   = rx;
		pos_y[1]   = ry;
		pos_dir[1] = rd;
		crash_m[0] = 1'b0;
		crash_m[1] = 1'b0;
		drive_heads();
		@(negedge Clk);
		check_flag("blue crash with run low", crash_m[0], blue_crash);
		check_flag("red crash with run low", crash_m[1], red_crash);
		run = 1'b1;
	endtask

	task automatic move_heads(input string name, input logic move_b, input dir_t dir_b,
		input logic move_r, input dir_t dir_r);
		logic [COORD_BITS-1:0] old_x [0:1];
		logic [COORD_BITS-1:0] old_y [0:1];
		logic                  mv [0:1];
		dir_t                  nd [0:1];
		int                    n;
		mv[0] = move_b;
		mv[1] = move_r;
		nd[0] = dir_b;
		nd[1] = dir_r;
		for (int p = 0; p < 2; p++)
		begin
			old_x[p] = pos_x[p];
			old_y[p] = pos_y[p];
			if (mv[p])
				step_player(p, nd[p]);
		end
		@(negedge Clk);
		drive_heads();
		@(negedge Clk);
		if (mv[0])
			check_flag({name, " blue busy"}, 1'b1, blue_busy);
		if (mv[1])
			check_flag({name, " red busy"}, 1'b1, red_busy);
		n = 0;
		while (blue_busy || red_busy)
		begin
			if (n >= MOVE_TIMEOUT)
				abort_run($sformatf("%s: busy never fell after the move", name));
			n++;
			@(negedge Clk);
		end
		check_flag({name, " blue crash"}, crash_m[0], blue_crash);
		check_flag({name, " red crash"}, crash_m[1], red_crash);
		for (int p = 0; p < 2; p++)
		begin
			if (mv[p])
			begin
				check_cell({name, " old cell"}, old_x[p], old_y[p]);
				check_cell({name, " head cell"}, pos_x[p], pos_y[p]);
			end
		end
	endtask

	initial
	begin
		int   cycles;
		int   r;
		int   n;
		dir_t d [0:1];
		seed     = 38;
		arst_n   = 1'b0;
		run      = 1'b0;
		clear    = 1'b0;
		blue_x   = '0;
		blue_y   = '0;
		blue_dir = DIR_UP;
		red_x    = '0;
		red_y    = '0;
		red_dir  = DIR_UP;
		vid_addr = '0;
		for (n = 0; n < DEPTH; n++)
			grid[n] = CELL_EMPTY;

		repeat (8) @(negedge Clk);
		check_flag("ready in reset", 1'b0, ready);
		check_flag("blue busy in reset", 1'b0, blue_busy);
		check_flag("red busy in reset", 1'b0, red_busy);
		arst_n = 1'b1;
		wait_ready("reset sweep", cycles);
		check_count("reset sweep length", DEPTH, cycles);
		check_grid("empty after reset");

		// straight runs
		start_round(5'd2, 5'd4, DIR_RIGHT, 5'd20, 5'd10, DIR_UP);
		repeat (3) move_heads("blue straight", 1'b1, DIR_RIGHT, 1'b0, DIR_UP);
		repeat (2) move_heads("red straight", 1'b0, DIR_RIGHT, 1'b1, DIR_UP);

		// turns leave corners
		move_heads("blue turn down", 1'b1, DIR_DOWN, 1'b0, DIR_UP);
		move_heads("blue down", 1'b1, DIR_DOWN, 1'b0, DIR_UP);
		move_heads("blue turn left", 1'b1, DIR_LEFT, 1'b0, DIR_UP);
		move_heads("blue turn up", 1'b1, DIR_UP, 1'b0, DIR_UP);

		// blue enters its own earlier trail at (4,4)
		move_heads("blue crash move", 1'b1, DIR_UP, 1'b0, DIR_UP);
		check_flag("blue crash set", 1'b1, blue_crash);
		check_flag("red crash untouched", 1'b0, red_crash);
		move_heads("blue after crash", 1'b1, DIR_UP, 1'b0, DIR_UP);
		move_heads("red turn left", 1'b0, DIR_UP, 1'b1, DIR_LEFT);
		check_flag("blue crash held", 1'b1, blue_crash);
		check_flag("red crash still clear", 1'b0, red_crash);

		// red loops back onto its own trail at (20,9)
		move_heads("red turn down", 1'b0, DIR_UP, 1'b1, DIR_DOWN);
		move_heads("red crash move", 1'b0, DIR_UP, 1'b1, DIR_RIGHT);
		check_flag("red crash set", 1'b1, red_crash);
		check_grid("directed trails");

		// run drop clears both flags
		start_round(5'd8, 5'd20, DIR_UP, 5'd24, 5'd20, DIR_DOWN);
		check_flag("blue crash after run drop", 1'b0, blue_crash);
		check_flag("red crash after run drop", 1'b0, red_crash);

		// both heads move in the same cycle every step
		for (n = 0; n < RANDOM_MOVES; n++)
		begin
			for (int p = 0; p < 2; p++)
			begin
				r    = $random(seed);
				d[p] = dir_t'(r[1:0]);
				if (leaves_half(p, d[p]))
					d[p] = dir_t'(d[p] ^ 2'b01);
			end
			move_heads($sformatf("random move %0d", n), 1'b1, d[0], 1'b1, d[1]);
		end
		check_grid("random trails");

		@(negedge Clk);
		clear = 1'b1;
		@(negedge Clk);
		clear = 1'b0;
		wait_ready("clear sweep", cycles);
		check_count("clear sweep length", DEPTH, cycles);
		for (n = 0; n < DEPTH; n++)
			grid[n] = CELL_EMPTY;
		check_grid("empty after clear");

		$display("=== PASS ===");
		$finish;
	end

endmodule
